/* hw/depunc_macros.svh */
`ifndef DEPUNC_MACROS_SVH
`define DEPUNC_MACROS_SVH

// bits per soft value, two's complement, positive leans to bit 0
`define DP_SW 4

// log2 of the soft pair buffer depth
`define DP_FIFO_AW 4
`define DP_FIFO_DEPTH (1 << `DP_FIFO_AW)

// two extra bits hold the sum of two terms that each reach 2M
`define DP_BM_W (`DP_SW + 2)

`endif

/* hw/depunc_pkg.sv */
`include "depunc_macros.svh"

package depunc_pkg;

  // one signed soft decision
  typedef logic signed [`DP_SW-1:0] soft_t;

  // received pair, first transmitted value in the upper half
  typedef logic [2*`DP_SW-1:0] soft_pair_t;

  // branch metric, larger means more likely
  typedef logic [`DP_BM_W-1:0] bm_t;

  typedef enum logic [1:0] {
    RATE_1_2 = 2'd0,
    RATE_2_3 = 2'd1,
    RATE_3_4 = 2'd2
  } rate_t;

endpackage

/* hw/soft_fifo.sv */
`timescale 1ns/1ps
`include "depunc_macros.svh"

module soft_fifo (
  input  logic                   clk,
  input  logic                   nrst,
  input  logic                   wr,
  input  depunc_pkg::soft_pair_t wdata,
  input  logic                   rd,
  output logic                   dav,
  output depunc_pkg::soft_pair_t din,
  output logic                   full
);

  import depunc_pkg::*;

  soft_pair_t                mem [`DP_FIFO_DEPTH];
  logic [`DP_FIFO_AW-1:0]    wr_ptr;
  logic [`DP_FIFO_AW-1:0]    rd_ptr;
  logic [`DP_FIFO_AW:0]      count;
  logic                      do_wr;
  logic                      do_rd;

  // writes into a full buffer are dropped here
  assign do_wr = wr & ~full;
  assign do_rd = rd & dav;

  assign dav  = (count != '0);
  assign full = (count == (`DP_FIFO_AW+1)'(`DP_FIFO_DEPTH));

  // show-ahead, the head entry is visible before it is popped
  assign din = mem[rd_ptr];

  // ======================================================================
  // storage
  // ======================================================================

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // ======================================================================
  // pointers and occupancy
  // ======================================================================

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      wr_ptr <= '0;
    end else if (do_wr) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      rd_ptr <= '0;
    end else if (do_rd) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // a write and a pop on the same edge leave the count alone
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      count <= '0;
    end else begin
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* hw/depunc.sv */
`timescale 1ns/1ps
`include "depunc_macros.svh"

module depunc (
  input  logic                   clk,
  input  logic                   nrst,
  input  logic                   start,
  input  depunc_pkg::rate_t      rate,
  input  logic                   dav,
  input  depunc_pkg::soft_pair_t din,
  output logic                   buf_rd,
  output logic                   vout,
  output depunc_pkg::soft_t      dout_a,
  output depunc_pkg::soft_t      dout_b
);

  import depunc_pkg::*;

  logic [1:0]  phase;
  logic        hold;
  logic        hold_d;
  logic        hold_pulse;
  soft_pair_t  last_word;
  soft_t       cur_p;
  soft_t       cur_q;
  soft_t       last_q;

  assign cur_p  = din[2*`DP_SW-1:`DP_SW];
  assign cur_q  = din[`DP_SW-1:0];
  assign last_q = last_word[`DP_SW-1:0];

  // ======================================================================
  // puncture phase
  // ======================================================================

  // rate 1/2 has a single phase and never leaves 0
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      phase <= 2'd0;
    end else if (start) begin
      phase <= 2'd0;
    end else if (dav) begin
      case (rate)
        RATE_2_3: phase <= phase + 2'd1;
        RATE_3_4: phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
        default:  phase <= 2'd0;
      endcase
    end
  end

  // the last phase of each punctured rate replays the latched word
  // and leaves the buffer alone
  assign hold = ((rate == RATE_2_3) && (phase == 2'd3)) ||
                ((rate == RATE_3_4) && (phase == 2'd2));

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      hold_d <= 1'b0;
    end else begin
      hold_d <= hold;
    end
  end

  // held value goes out once, on entry to the hold phase
  assign hold_pulse = hold & ~hold_d;

  assign buf_rd = dav & ~hold;
  assign vout   = buf_rd | hold_pulse;

  always_ff @(posedge clk) begin
    if (buf_rd) begin
      last_word <= din;
    end
  end

  // ======================================================================
  // erasure insertion
  // ======================================================================

  always_comb begin
    dout_a = '0;
    dout_b = '0;
    case (rate)
      RATE_2_3: begin
        case (phase)
          2'd0: begin
            dout_a = cur_p;
            dout_b = cur_q;
          end
          2'd1: begin
            dout_a = cur_p;
          end
          2'd2: begin
            // pairs the low half of the previous word with this one
            dout_a = last_q;
            dout_b = cur_p;
          end
          default: begin
            dout_a = last_q;
          end
        endcase
      end
      RATE_3_4: begin
        case (phase)
          2'd0: begin
            dout_a = cur_p;
            dout_b = cur_q;
          end
          2'd1: begin
            dout_a = cur_p;
          end
          default: begin
            dout_b = last_q;
          end
        endcase
      end
      default: begin
        dout_a = cur_p;
        dout_b = cur_q;
      end
    endcase
  end

endmodule

/* hw/branch_metric.sv */
`timescale 1ns/1ps
`include "depunc_macros.svh"

module branch_metric (
  input  logic              clk,
  input  logic              nrst,
  input  logic              vin,
  input  depunc_pkg::soft_t a,
  input  depunc_pkg::soft_t b,
  output logic              bm_valid,
  output depunc_pkg::bm_t   bm_00,
  output depunc_pkg::bm_t   bm_01,
  output depunc_pkg::bm_t   bm_10,
  output depunc_pkg::bm_t   bm_11
);

  import depunc_pkg::*;

  // offset that maps a soft value onto 0 .. 2M
  localparam bm_t M = bm_t'(1) << (`DP_SW - 1);

  bm_t a_ext;
  bm_t b_ext;
  bm_t a_0;
  bm_t a_1;
  bm_t b_0;
  bm_t b_1;

  assign a_ext = {{2{a[`DP_SW-1]}}, a};
  assign b_ext = {{2{b[`DP_SW-1]}}, b};

  // an erasure gives M under either hypothesis
  assign a_0 = M + a_ext;
  assign a_1 = M - a_ext;
  assign b_0 = M + b_ext;
  assign b_1 = M - b_ext;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      bm_valid <= 1'b0;
    end else begin
      bm_valid <= vin;
    end
  end

  always_ff @(posedge clk) begin
    if (vin) begin
      bm_00 <= a_0 + b_0;
      bm_01 <= a_0 + b_1;
      bm_10 <= a_1 + b_0;
      bm_11 <= a_1 + b_1;
    end
  end

endmodule

/* hw/depunc_top.sv */
`timescale 1ns/1ps

module depunc_top (
  input  logic                   clk,
  input  logic                   nrst,
  input  logic                   start,
  input  depunc_pkg::rate_t      rate,
  input  logic                   in_wr,
  input  depunc_pkg::soft_pair_t in_data,
  output logic                   in_full,
  output logic                   bm_valid,
  output depunc_pkg::bm_t        bm_00,
  output depunc_pkg::bm_t        bm_01,
  output depunc_pkg::bm_t        bm_10,
  output depunc_pkg::bm_t        bm_11
);

  import depunc_pkg::*;

  logic        dav;
  logic        buf_rd;
  soft_pair_t  head;
  logic        vout;
  soft_t       dout_a;
  soft_t       dout_b;

  // ======================================================================
  // buffer, depuncturer and metric unit in a chain
  // ======================================================================

  soft_fifo u_fifo (
    .clk   (clk),
    .nrst  (nrst),
    .wr    (in_wr),
    .wdata (in_data),
    .rd    (buf_rd),
    .dav   (dav),
    .din   (head),
    .full  (in_full)
  );

  depunc u_depunc (
    .clk    (clk),
    .nrst   (nrst),
    .start  (start),
    .rate   (rate),
    .dav    (dav),
    .din    (head),
    .buf_rd (buf_rd),
    .vout   (vout),
    .dout_a (dout_a),
    .dout_b (dout_b)
  );

  branch_metric u_bm (
    .clk      (clk),
    .nrst     (nrst),
    .vin      (vout),
    .a        (dout_a),
    .b        (dout_b),
    .bm_valid (bm_valid),
    .bm_00    (bm_00),
    .bm_01    (bm_01),
    .bm_10    (bm_10),
    .bm_11    (bm_11)
  );

endmodule

/* verif/depunc_checker.sv */
`timescale 1ns/1ps
`include "depunc_macros.svh"

module depunc_checker (
  input  logic            clk,
  input  logic            nrst,
  input  logic            bm_valid,
  input  depunc_pkg::bm_t bm_00,
  input  depunc_pkg::bm_t bm_01,
  input  depunc_pkg::bm_t bm_10,
  input  depunc_pkg::bm_t bm_11
);

  import depunc_pkg::*;

  // four metrics packed as {bm_00, bm_01, bm_10, bm_11}
  typedef logic [4*`DP_BM_W-1:0] bm_set_t;

  bm_set_t exp_q [$];
  int      err_count = 0;
  int      set_count = 0;

  task automatic expect_set(input bm_t e00, input bm_t e01, input bm_t e10, input bm_t e11);
    exp_q.push_back({e00, e01, e10, e11});
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic compare(input string name, input bm_t exp_v, input bm_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp_v, act_v);
      err_count++;
    end
  endtask

  // the metric outputs are registered, so mid-cycle they are settled
  always @(negedge clk) begin : watch
    bm_set_t e;
    if (nrst && bm_valid) begin
      // every output counts toward the total, expected or not
      set_count++;
      if (exp_q.size() == 0) begin
        $display("metric set at t=%0t arrived while no result was expected", $time);
        err_count++;
      end else begin
        e = exp_q.pop_front();
        compare("bm_00", e[4*`DP_BM_W-1 -: `DP_BM_W], bm_00);
        compare("bm_01", e[3*`DP_BM_W-1 -: `DP_BM_W], bm_01);
        compare("bm_10", e[2*`DP_BM_W-1 -: `DP_BM_W], bm_10);
        compare("bm_11", e[`DP_BM_W-1 -: `DP_BM_W], bm_11);
      end
    end
  end

endmodule

/* verif/depunc_tb.sv */
`timescale 1ns/1ps
`include "depunc_macros.svh"

module depunc_tb;

  import depunc_pkg::*;

  localparam int NROWS = 9;
  localparam int M = 1 << (`DP_SW - 1);

  logic       clk;
  logic       nrst;
  logic       start;
  rate_t      rate;
  logic       in_wr;
  soft_pair_t in_data;
  logic       in_full;
  logic       bm_valid;
  bm_t        bm_00;
  bm_t        bm_01;
  bm_t        bm_10;
  bm_t        bm_11;

  int     row_rate [NROWS];
  int     row_words [NROWS];
  bit     row_start [NROWS];
  bit     row_fixed [NROWS];
  int     wp [$];
  int     wq [$];
  integer seed = 95749;
  int     model_phase;
  int     model_last_q;
  int     row_sets;
  int     total_sets;
  int     tb_errs;
  bit     timed_out;

  depunc_top uut (
    .clk      (clk),
    .nrst     (nrst),
    .start    (start),
    .rate     (rate),
    .in_wr    (in_wr),
    .in_data  (in_data),
    .in_full  (in_full),
    .bm_valid (bm_valid),
    .bm_00    (bm_00),
    .bm_01    (bm_01),
    .bm_10    (bm_10),
    .bm_11    (bm_11)
  );

  depunc_checker u_chk (
    .clk      (clk),
    .nrst     (nrst),
    .bm_valid (bm_valid),
    .bm_00    (bm_00),
    .bm_01    (bm_01),
    .bm_10    (bm_10),
    .bm_11    (bm_11)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ====================================================================
  // reference model
  // ====================================================================

  function automatic int term(int s, bit hyp);
    return hyp ? (M - s) : (M + s);
  endfunction

  task automatic expect_pair(int a, int b);
    u_chk.expect_set(bm_t'(term(a, 0) + term(b, 0)), bm_t'(term(a, 0) + term(b, 1)),
                     bm_t'(term(a, 1) + term(b, 0)), bm_t'(term(a, 1) + term(b, 1)));
    row_sets++;
  endtask

  // restores the mother-code pairs of one received word, zero is an erasure
  task automatic model_word(int r, int p, int q);
    if (r == 1) begin
      case (model_phase)
        0: expect_pair(p, q);
        1: begin
          expect_pair(p, 0);
          model_last_q = q;
        end
        default: begin
          expect_pair(model_last_q, p);
          expect_pair(q, 0);
        end
      endcase
      model_phase = (model_phase + 1) % 3;
    end else if (r == 2) begin
      if (model_phase == 0) begin
        expect_pair(p, q);
      end else begin
        expect_pair(p, 0);
        expect_pair(0, q);
      end
      model_phase = 1 - model_phase;
    end else begin
      expect_pair(p, q);
    end
  endtask

  // fixed mode walks every pairing of most negative, most positive and zero
  task automatic make_words(int n, bit fixed);
    int    ext [3];
    int    r;
    soft_t s;
    ext[0] = -M;
    ext[1] = M - 1;
    ext[2] = 0;
    wp.delete();
    wq.delete();
    for (int i = 0; i < n; i++) begin
      if (fixed) begin
        wp.push_back(ext[i % 3]);
        wq.push_back(ext[(i / 3) % 3]);
      end else begin
        r = $random(seed);
        s = r[2*`DP_SW-1:`DP_SW];
        wp.push_back(int'(s));
        s = r[`DP_SW-1:0];
        wq.push_back(int'(s));
      end
    end
  endtask

  // ====================================================================
  // stimulus table
  // ====================================================================

  task automatic set_row(int idx, int r, int n, bit st, bit fixed);
    row_rate[idx]  = r;
    row_words[idx] = n;
    row_start[idx] = st;
    row_fixed[idx] = fixed;
  endtask

  task automatic check_low(string name, logic v);
    if (v !== 1'b0) begin
      $display("ERR t=%0t %s expected 0 got %b", $time, name, v);
      tb_errs++;
    end
  endtask

  task automatic run_row(int idx);
    int limit;
    int errs_before;
    errs_before = u_chk.err_count;
    row_sets = 0;
    if (row_start[idx]) begin
      @(posedge clk);
      start <= 1'b1;
      rate  <= rate_t'(row_rate[idx]);
      @(posedge clk);
      start <= 1'b0;
      model_phase = 0;
    end
    make_words(row_words[idx], row_fixed[idx]);
    for (int i = 0; i < row_words[idx]; i++) begin
      model_word(row_rate[idx], wp[i], wq[i]);
    end
    total_sets += row_sets;
    for (int i = 0; i < row_words[idx]; i++) begin
      @(posedge clk);
      in_wr   <= 1'b1;
      in_data <= {soft_t'(wp[i]), soft_t'(wq[i])};
    end
    @(posedge clk);
    in_wr <= 1'b0;
    limit = 40 + 4 * row_words[idx];
    while (u_chk.pending() != 0 && limit > 0) begin
      @(posedge clk);
      limit--;
    end
    if (u_chk.pending() != 0) begin
      $display("row %0d timed out with %0d metric sets never produced", idx, u_chk.pending());
      timed_out = 1'b1;
    end
    // a few idle cycles let any stray extra output reach the checker
    repeat (4) @(posedge clk);
    $display("row %0d rate %0d words %0d sets %0d errors %0d", idx, row_rate[idx],
             row_words[idx], row_sets, u_chk.err_count - errs_before);
  endtask

  initial begin
    nrst         = 1'b0;
    start        = 1'b0;
    rate         = RATE_1_2;
    in_wr        = 1'b0;
    in_data      = '0;
    tb_errs      = 0;
    timed_out    = 1'b0;
    model_phase  = 0;
    model_last_q = 0;
    total_sets   = 0;
    set_row(0, 0, 12, 1'b1, 1'b0);
    set_row(1, 0, 9, 1'b0, 1'b1);
    set_row(2, 1, 12, 1'b1, 1'b0);
    set_row(3, 1, 4, 1'b0, 1'b0);
    set_row(4, 1, 9, 1'b1, 1'b0);
    set_row(5, 2, 10, 1'b1, 1'b0);
    set_row(6, 2, 5, 1'b0, 1'b0);
    set_row(7, 2, 8, 1'b1, 1'b1);
    set_row(8, 1, 9, 1'b1, 1'b1);
    repeat (5) @(posedge clk);
    nrst <= 1'b1;
    @(negedge clk);
    check_low("bm_valid", bm_valid);
    check_low("in_full", in_full);
    repeat (8) @(posedge clk);
    $display("reset and idle test errors %0d", tb_errs + u_chk.err_count);
    for (int i = 0; i < NROWS && !timed_out; i++) begin
      run_row(i);
    end
    if (!timed_out && u_chk.set_count != total_sets) begin
      $display("expected %0d metric sets in total but %0d were checked", total_sets,
               u_chk.set_count);
      tb_errs++;
    end
    $display("rows %0d sets expected %0d checked %0d errors %0d", NROWS, total_sets,
             u_chk.set_count, tb_errs + u_chk.err_count);
    if (tb_errs + u_chk.err_count == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+hw
hw/depunc_pkg.sv
hw/soft_fifo.sv
hw/depunc.sv
hw/branch_metric.sv
hw/depunc_top.sv
verif/depunc_checker.sv
verif/depunc_tb.sv
